/* verilog/g729SeqPkg.sv */
`default_nettype none

package g729SeqPkg;

	//////////////////////////////////////////////////////////////////////
	// Processing units
	//////////////////////////////////////////////////////////////////////

	// Value is the bit position in unitStart and unitDone
	typedef enum logic [4:0]
	{
		UNIT_AUTOCORR,
		UNIT_LAG,
		UNIT_LEVINSON,
		UNIT_AZ,
		UNIT_QUA_LSP,
		UNIT_INT_LPC,
		UNIT_INT_QLPC,
		UNIT_MATH1,
		UNIT_PERC_VAR,
		UNIT_WEIGHT_AZ,
		UNIT_RESIDU,
		UNIT_SYN_FILT,
		UNIT_PITCH_OL,
		UNIT_MATH2,
		UNIT_MATH3,
		UNIT_PITCH_FR3,
		UNIT_ENC_LAG3,
		UNIT_PARITY_PITCH,
		UNIT_PRED_LT3,
		UNIT_CONVOLVE,
		UNIT_G_PITCH,
		UNIT_TEST_ERR,
		UNIT_MATH4,
		UNIT_ACELP,
		UNIT_MATH5,
		UNIT_CORR_XY2,
		UNIT_QUA_GAIN,
		UNIT_MATH6,
		UNIT_UPDATE_EXC,
		UNIT_MATH7,
		UNIT_COPY,
		UNIT_PRM2BITS
	} unitType;

	localparam int UNIT_COUNT = UNIT_PRM2BITS + 1;	// Width of start and done vectors

	//////////////////////////////////////////////////////////////////////
	// Step program
	//////////////////////////////////////////////////////////////////////

	typedef logic [5:0] stepType;	// Also the math mux select

	localparam stepType FRAME_FIRST = 6'd0;	// Autocorrelation
	localparam stepType FRAME_LAST = 6'd18;	// Math2
	localparam stepType SUB_FIRST = 6'd19;	// Start of subframe body
	localparam stepType SUB_LAST = 6'd44;
	localparam stepType PARITY_STEP = 6'd31;	// First subframe only
	localparam stepType CLOSE_FIRST = 6'd45;	// Three copies, then bit packing
	localparam stepType CLOSE_LAST = 6'd48;

	// Subframe loop bounds in samples
	localparam logic [7:0] L_FRAME = 8'd80;
	localparam logic [7:0] L_SUBFR = 8'd40;

	//////////////////////////////////////////////////////////////////////
	// Frame gate and controller
	//////////////////////////////////////////////////////////////////////

	localparam int FRAMES_PER_WINDOW = 2;	// Arrival pulses per analysis window
	localparam int GATE_COUNT_WIDTH = $clog2(FRAMES_PER_WINDOW + 1);

	typedef enum logic [2:0]
	{
		SEQ_IDLE,
		SEQ_WAIT_FRAME,	// Armed, waiting for frameReady
		SEQ_ISSUE,	// One-cycle unit start
		SEQ_WAIT_DONE,
		SEQ_FINISH	// One-cycle done
	} seqStateType;

endpackage

`default_nettype wire

/* verilog/frameGate.sv */
`timescale 1ns/100ps
`default_nettype none

module frameGate
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic frameDone,
	output logic frameReady
);

	logic armed;	// Set once by start, held until reset
	logic [g729SeqPkg::GATE_COUNT_WIDTH-1:0] frameCount;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			armed <= 1'b0;
			frameCount <= '0;
			frameReady <= 1'b0;
		end
		else
		begin
			frameReady <= 1'b0;	// Single-cycle pulse
			if (!armed)
				armed <= start;
			else if (frameDone)
			begin
				// Last pulse of the window wraps the count
				if (frameCount == g729SeqPkg::GATE_COUNT_WIDTH'(g729SeqPkg::FRAMES_PER_WINDOW - 1))
				begin
					frameCount <= '0;
					frameReady <= 1'b1;
				end
				else
					frameCount <= frameCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/stepProgram.sv */
`timescale 1ns/100ps
`default_nettype none

module stepProgram
(
	input g729SeqPkg::stepType step,
	output g729SeqPkg::unitType unit
);

	always_comb
	begin
		case (step)
			//////////////////////////////////////////////////////////////////////
			// Frame analysis
			//////////////////////////////////////////////////////////////////////
			6'd0: unit = g729SeqPkg::UNIT_AUTOCORR;
			6'd1: unit = g729SeqPkg::UNIT_LAG;
			6'd2: unit = g729SeqPkg::UNIT_LEVINSON;
			6'd3: unit = g729SeqPkg::UNIT_AZ;
			6'd4: unit = g729SeqPkg::UNIT_QUA_LSP;
			6'd5: unit = g729SeqPkg::UNIT_INT_LPC;
			6'd6: unit = g729SeqPkg::UNIT_INT_QLPC;
			6'd7: unit = g729SeqPkg::UNIT_MATH1;
			6'd8: unit = g729SeqPkg::UNIT_PERC_VAR;
			6'd9: unit = g729SeqPkg::UNIT_WEIGHT_AZ;	// First subframe weights
			6'd10: unit = g729SeqPkg::UNIT_WEIGHT_AZ;
			6'd11: unit = g729SeqPkg::UNIT_RESIDU;
			6'd12: unit = g729SeqPkg::UNIT_SYN_FILT;
			6'd13: unit = g729SeqPkg::UNIT_WEIGHT_AZ;	// Second subframe weights
			6'd14: unit = g729SeqPkg::UNIT_WEIGHT_AZ;
			6'd15: unit = g729SeqPkg::UNIT_RESIDU;
			6'd16: unit = g729SeqPkg::UNIT_SYN_FILT;
			6'd17: unit = g729SeqPkg::UNIT_PITCH_OL;	// Open-loop pitch
			6'd18: unit = g729SeqPkg::UNIT_MATH2;	// T0 search range

			//////////////////////////////////////////////////////////////////////
			// Subframe body
			//////////////////////////////////////////////////////////////////////
			6'd19: unit = g729SeqPkg::UNIT_WEIGHT_AZ;
			6'd20: unit = g729SeqPkg::UNIT_WEIGHT_AZ;
			6'd21: unit = g729SeqPkg::UNIT_MATH3;
			6'd22: unit = g729SeqPkg::UNIT_SYN_FILT;	// Impulse response
			6'd23: unit = g729SeqPkg::UNIT_SYN_FILT;
			6'd24: unit = g729SeqPkg::UNIT_RESIDU;	// Target signal
			6'd25: unit = g729SeqPkg::UNIT_SYN_FILT;
			6'd26: unit = g729SeqPkg::UNIT_RESIDU;
			6'd27: unit = g729SeqPkg::UNIT_SYN_FILT;
			6'd28: unit = g729SeqPkg::UNIT_PITCH_FR3;	// Closed-loop pitch
			6'd29: unit = g729SeqPkg::UNIT_ENC_LAG3;
			6'd30: unit = g729SeqPkg::UNIT_MATH2;	// Updates T0 range for next subframe
			6'd31: unit = g729SeqPkg::UNIT_PARITY_PITCH;	// Skipped after subframe 0
			6'd32: unit = g729SeqPkg::UNIT_PRED_LT3;
			6'd33: unit = g729SeqPkg::UNIT_CONVOLVE;
			6'd34: unit = g729SeqPkg::UNIT_G_PITCH;
			6'd35: unit = g729SeqPkg::UNIT_TEST_ERR;
			6'd36: unit = g729SeqPkg::UNIT_MATH4;
			6'd37: unit = g729SeqPkg::UNIT_ACELP;	// Fixed codebook
			6'd38: unit = g729SeqPkg::UNIT_MATH5;
			6'd39: unit = g729SeqPkg::UNIT_CORR_XY2;
			6'd40: unit = g729SeqPkg::UNIT_QUA_GAIN;
			6'd41: unit = g729SeqPkg::UNIT_MATH6;
			6'd42: unit = g729SeqPkg::UNIT_UPDATE_EXC;
			6'd43: unit = g729SeqPkg::UNIT_SYN_FILT;	// Filter memory update
			6'd44: unit = g729SeqPkg::UNIT_MATH7;

			//////////////////////////////////////////////////////////////////////
			// Frame close
			//////////////////////////////////////////////////////////////////////
			6'd45: unit = g729SeqPkg::UNIT_COPY;
			6'd46: unit = g729SeqPkg::UNIT_COPY;
			6'd47: unit = g729SeqPkg::UNIT_COPY;
			6'd48: unit = g729SeqPkg::UNIT_PRM2BITS;	// Bit packing

			// Steps past the program are never issued
			default: unit = g729SeqPkg::UNIT_AUTOCORR;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/stepController.sv */
`timescale 1ns/100ps
`default_nettype none

module stepController
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic frameReady,
	input logic unitFinished,
	output g729SeqPkg::stepType step,
	output logic issue,
	output logic done
);

	g729SeqPkg::seqStateType state;
	logic [7:0] subIndex;	// First sample of current subframe
	logic [7:0] nextSubIndex;
	logic skipParity;

	assign nextSubIndex = subIndex + g729SeqPkg::L_SUBFR;

	// Parity pitch belongs to the first subframe only
	assign skipParity = (step == g729SeqPkg::stepType'(g729SeqPkg::PARITY_STEP - 6'd1))
		&& (subIndex != 8'd0);

	// Both strobes decode the registered state
	assign issue = (state == g729SeqPkg::SEQ_ISSUE);
	assign done = (state == g729SeqPkg::SEQ_FINISH);

	//////////////////////////////////////////////////////////////////////
	// Sequencing FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= g729SeqPkg::SEQ_IDLE;
			step <= g729SeqPkg::FRAME_FIRST;
			subIndex <= 8'd0;
		end
		else if (divErr)
			state <= g729SeqPkg::SEQ_IDLE;	// Abort returns to idle at once
		else
		begin
			case (state)
				g729SeqPkg::SEQ_IDLE:
				begin
					if (start)
						state <= g729SeqPkg::SEQ_WAIT_FRAME;
				end

				g729SeqPkg::SEQ_WAIT_FRAME:
				begin
					if (frameReady)
					begin
						step <= g729SeqPkg::FRAME_FIRST;
						subIndex <= 8'd0;
						state <= g729SeqPkg::SEQ_ISSUE;
					end
				end

				g729SeqPkg::SEQ_ISSUE:
				begin
					state <= g729SeqPkg::SEQ_WAIT_DONE;
				end

				g729SeqPkg::SEQ_WAIT_DONE:
				begin
					// No limit on how long a unit may take
					if (unitFinished)
					begin
						if (step == g729SeqPkg::CLOSE_LAST)
							state <= g729SeqPkg::SEQ_FINISH;
						else
						begin
							state <= g729SeqPkg::SEQ_ISSUE;
							if (step == g729SeqPkg::FRAME_LAST)
								step <= g729SeqPkg::SUB_FIRST;	// Enter subframe loop
							else if (step == g729SeqPkg::SUB_LAST)
							begin
								subIndex <= nextSubIndex;
								if (nextSubIndex < g729SeqPkg::L_FRAME)
									step <= g729SeqPkg::SUB_FIRST;	// Next subframe
								else
									step <= g729SeqPkg::CLOSE_FIRST;
							end
							else if (skipParity)
								step <= g729SeqPkg::stepType'(g729SeqPkg::PARITY_STEP + 6'd1);
							else
								step <= step + 6'd1;
						end
					end
				end

				g729SeqPkg::SEQ_FINISH:
				begin
					// Gate stays armed, so the next window can follow directly
					if (start)
						state <= g729SeqPkg::SEQ_WAIT_FRAME;
					else
						state <= g729SeqPkg::SEQ_IDLE;
				end

				default:
				begin
					state <= g729SeqPkg::SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/unitPort.sv */
`timescale 1ns/100ps
`default_nettype none

module unitPort
(
	input g729SeqPkg::unitType unit,
	input logic issue,
	input logic [g729SeqPkg::UNIT_COUNT-1:0] unitDone,
	output logic [g729SeqPkg::UNIT_COUNT-1:0] unitStart,
	output logic unitFinished
);

	//////////////////////////////////////////////////////////////////////
	// Start decode
	//////////////////////////////////////////////////////////////////////

	// One-hot on the unit's bit, all zero when not issuing
	always_comb
	begin
		unitStart = {{(g729SeqPkg::UNIT_COUNT - 1){1'b0}}, issue} << unit;
	end

	//////////////////////////////////////////////////////////////////////
	// Done select
	//////////////////////////////////////////////////////////////////////

	// Done bits of the other units are dropped here
	always_comb
	begin
		unitFinished = unitDone[unit];
	end

endmodule

`default_nettype wire

/* verilog/encoderSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module encoderSequencer
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic frameDone,
	input logic divErr,
	input logic [g729SeqPkg::UNIT_COUNT-1:0] unitDone,
	output logic [g729SeqPkg::UNIT_COUNT-1:0] unitStart,
	output g729SeqPkg::stepType mathMuxSel,
	output logic done
);

	logic frameReady;
	g729SeqPkg::stepType step;
	g729SeqPkg::unitType unit;
	logic issue;
	logic unitFinished;

	assign mathMuxSel = step;	// Mux select tracks the step number

	frameGate i_frameGate
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.frameReady(frameReady)
	);

	stepController i_stepController
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.frameReady(frameReady),
		.unitFinished(unitFinished),
		.step(step),
		.issue(issue),
		.done(done)
	);

	stepProgram i_stepProgram
	(
		.step(step),
		.unit(unit)
	);

	unitPort i_unitPort
	(
		.unit(unit),
		.issue(issue),
		.unitDone(unitDone),
		.unitStart(unitStart),
		.unitFinished(unitFinished)
	);

endmodule

`default_nettype wire

/* test/encoderSequencerTb.sv */
`timescale 1ns/100ps
`default_nettype none

module encoderSequencerTb;

	localparam int MAX_DELAY = 8;	// Longest unit response in cycles
	localparam int SUBFRAMES = g729SeqPkg::L_FRAME / g729SeqPkg::L_SUBFR;
	localparam int CALLS_PER_FRAME = g729SeqPkg::FRAME_LAST - g729SeqPkg::FRAME_FIRST + 1
		+ SUBFRAMES * (g729SeqPkg::SUB_LAST - g729SeqPkg::SUB_FIRST + 1) - (SUBFRAMES - 1)
		+ g729SeqPkg::CLOSE_LAST - g729SeqPkg::CLOSE_FIRST + 1;
	localparam int FRAME_CYCLES = CALLS_PER_FRAME * (MAX_DELAY + 1) + 16;
	localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 200;	// Four frames plus idle gaps
	localparam int ABORT_AFTER = g729SeqPkg::SUB_FIRST + 8;	// Inside subframe 0

	logic clock;
	logic reset;
	logic start;
	logic frameDone;
	logic divErr;
	logic [g729SeqPkg::UNIT_COUNT-1:0] unitDone;
	logic [g729SeqPkg::UNIT_COUNT-1:0] unitStart;
	g729SeqPkg::stepType mathMuxSel;
	logic done;

	int cycleCount;
	int errorCount;
	int checksRun;
	logic [15:0] lfsrState;
	g729SeqPkg::stepType expectedSteps[$];
	int orderIndex;	// Starts seen in the current frame
	int parityCalls;
	int doneTotal;
	int firstStartCycle;
	int lastDoneCycle;
	logic startsAllowed;
	g729SeqPkg::unitType lastUnit;
	g729SeqPkg::stepType lastStep;

	encoderSequencer i_encoderSequencer
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.divErr(divErr),
		.unitDone(unitDone),
		.unitStart(unitStart),
		.mathMuxSel(mathMuxSel),
		.done(done)
	);

	always #5 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, %0d errors so far", cycleCount, errorCount);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic checkUnit(input g729SeqPkg::unitType actual, expected, input string what);
		checksRun++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("** Error at %0t ns: %s is %s, expected %s", $time, what,
				actual.name(), expected.name());
		end
	endtask

	task automatic checkStep(input g729SeqPkg::stepType actual, expected, input string what);
		checksRun++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic checkBit(input logic actual, expected, input string what);
		checksRun++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic checkNumber(input int actual, expected, input string what);
		checksRun++;
		if (actual != expected)
		begin
			errorCount++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsrBit();
		logic feedback;
		feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], feedback};
		return feedback;
	endfunction

	function automatic int responseDelay();
		int value;
		value = 0;
		repeat (3)
			value = (value << 1) | lfsrBit();	// One step per bit
		return value + 1;	// 1 to MAX_DELAY
	endfunction

	function automatic g729SeqPkg::unitType startedUnit(
		input logic [g729SeqPkg::UNIT_COUNT-1:0] vector);
		int position;
		position = 0;
		for (int i = 0; i < g729SeqPkg::UNIT_COUNT; i++)
			if (vector[i])
				position = i;
		return g729SeqPkg::unitType'(position);
	endfunction

	// Opening steps, two subframe passes with parity in the first only, closing steps
	task automatic buildExpectedSteps();
		expectedSteps.delete();
		for (int s = g729SeqPkg::FRAME_FIRST; s <= g729SeqPkg::FRAME_LAST; s++)
			expectedSteps.push_back(g729SeqPkg::stepType'(s));
		for (int index = 0; index < g729SeqPkg::L_FRAME; index += g729SeqPkg::L_SUBFR)
			for (int s = g729SeqPkg::SUB_FIRST; s <= g729SeqPkg::SUB_LAST; s++)
				if (s != g729SeqPkg::PARITY_STEP || index == 0)
					expectedSteps.push_back(g729SeqPkg::stepType'(s));
		for (int s = g729SeqPkg::CLOSE_FIRST; s <= g729SeqPkg::CLOSE_LAST; s++)
			expectedSteps.push_back(g729SeqPkg::stepType'(s));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Unit model and monitor
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock)
	begin : respondToStart
		int delay;
		int position;
		if (!reset && unitStart != '0)
		begin
			position = startedUnit(unitStart);
			delay = responseDelay();
			for (int c = 1; c <= delay; c++)
			begin
				@(posedge clock);
				#1;
				unitDone = '0;
				if (c == delay)
					unitDone[position] = 1'b1;
				else if (c == 1)
					unitDone[(position + 1) % g729SeqPkg::UNIT_COUNT] = 1'b1;	// Wrong unit
			end
			@(posedge clock);
			#1;
			unitDone = '0;
		end
	end

	always @(negedge clock)
	begin
		if (!reset)
		begin
			if (unitStart != '0)
			begin
				if (!startsAllowed)
				begin
					errorCount++;
					$display("Unit start at %0t ns while none was expected", $time);
				end
				checkBit((unitStart & (unitStart - 1'b1)) == '0, 1'b1, "start vector one-hot");
				if (orderIndex == 0)
					firstStartCycle = cycleCount;
				else
					checkNumber(cycleCount, lastDoneCycle + 1, "cycle of start after done");
				lastUnit = startedUnit(unitStart);
				lastStep = mathMuxSel;
				if (orderIndex < expectedSteps.size())
					checkStep(mathMuxSel, expectedSteps[orderIndex], "mux select at start");
				if (mathMuxSel == g729SeqPkg::FRAME_FIRST)
					checkUnit(lastUnit, g729SeqPkg::UNIT_AUTOCORR, "first unit");
				else if (mathMuxSel == g729SeqPkg::FRAME_LAST)
					checkUnit(lastUnit, g729SeqPkg::UNIT_MATH2, "last opening unit");
				else if (mathMuxSel == g729SeqPkg::PARITY_STEP)
					checkUnit(lastUnit, g729SeqPkg::UNIT_PARITY_PITCH, "parity step unit");
				else if (mathMuxSel >= g729SeqPkg::CLOSE_FIRST
					&& mathMuxSel < g729SeqPkg::CLOSE_LAST)
					checkUnit(lastUnit, g729SeqPkg::UNIT_COPY, "copy unit");
				else if (mathMuxSel == g729SeqPkg::CLOSE_LAST)
					checkUnit(lastUnit, g729SeqPkg::UNIT_PRM2BITS, "bit packing unit");
				if (lastUnit == g729SeqPkg::UNIT_PARITY_PITCH)
					parityCalls++;
				orderIndex++;
			end
			else if (orderIndex > 0)
				checkStep(mathMuxSel, lastStep, "mux select between starts");
			if (orderIndex > 0 && unitDone[lastUnit])
				lastDoneCycle = cycleCount;
			if (done)
			begin
				doneTotal++;
				checkUnit(lastUnit, g729SeqPkg::UNIT_PRM2BITS, "unit before done");
				checkNumber(cycleCount, lastDoneCycle + 1, "cycle of done");
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic waitCycles(input int count);
		repeat (count)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic pulseFrameDone(output int sampleEdge);
		frameDone = 1'b1;
		@(posedge clock);
		#1;
		frameDone = 1'b0;
		sampleEdge = cycleCount;	// Edge that sampled the pulse
	endtask

	task automatic beginFrameTracking();
		orderIndex = 0;
		parityCalls = 0;
		startsAllowed = 1'b0;
	endtask

	// One arrival must not start a frame but the second one does
	task automatic runWindow(input int gapCycles);
		int frameEdge;
		int doneBefore;
		int waited;
		doneBefore = doneTotal;
		beginFrameTracking();
		pulseFrameDone(frameEdge);
		waitCycles(gapCycles);
		startsAllowed = 1'b1;
		pulseFrameDone(frameEdge);
		waited = 0;
		while (doneTotal == doneBefore && waited < FRAME_CYCLES)
		begin
			waitCycles(1);
			waited++;
		end
		if (doneTotal == doneBefore)
		begin
			errorCount++;
			$display("Frame did not reach done within %0d cycles", FRAME_CYCLES);
		end
		checkNumber(firstStartCycle, frameEdge + 1, "cycle of first start");	// Gate plus issue
		checkNumber(orderIndex, expectedSteps.size(), "starts in frame");
		checkNumber(parityCalls, 1, "parity calls in frame");
		waitCycles(4);
		checkNumber(doneTotal, doneBefore + 1, "done pulses in frame");
		startsAllowed = 1'b0;
	endtask

	task automatic idleAfterReset();
		int sampleEdge;
		repeat (3)
		begin
			pulseFrameDone(sampleEdge);	// Gate not armed yet
			waitCycles(3);
		end
		checkBit(done, 1'b0, "done while idle");
		checkNumber(orderIndex, 0, "starts while idle");
		checkNumber(doneTotal, 0, "done pulses while idle");
	endtask

	task automatic gateFirstWindow();
		start = 1'b1;
		waitCycles(2);
		runWindow(12);
	endtask

	task automatic abortMidSubframe();
		int frameEdge;
		int doneBefore;
		beginFrameTracking();
		pulseFrameDone(frameEdge);
		waitCycles(1);
		startsAllowed = 1'b1;
		pulseFrameDone(frameEdge);
		while (orderIndex < ABORT_AFTER)
			waitCycles(1);
		divErr = 1'b1;
		start = 1'b0;
		waitCycles(1);
		divErr = 1'b0;
		startsAllowed = 1'b0;	// Controller back in idle
		doneBefore = doneTotal;
		pulseFrameDone(frameEdge);	// A full window must not restart the frame
		waitCycles(MAX_DELAY);
		pulseFrameDone(frameEdge);
		waitCycles(2 * MAX_DELAY);
		checkNumber(doneTotal, doneBefore, "done pulses after abort");
		start = 1'b1;
		waitCycles(2);
		runWindow(2);
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		frameDone = 1'b0;
		divErr = 1'b0;
		unitDone = '0;
		cycleCount = 0;
		errorCount = 0;
		checksRun = 0;
		lfsrState = 16'd19884;
		doneTotal = 0;
		firstStartCycle = 0;
		lastDoneCycle = 0;
		lastUnit = g729SeqPkg::UNIT_AUTOCORR;
		lastStep = g729SeqPkg::FRAME_FIRST;
		beginFrameTracking();
		buildExpectedSteps();
		repeat (8)
			@(posedge clock);
		#1;
		reset = 1'b0;

		idleAfterReset();
		gateFirstWindow();
		runWindow(2);	// Next window while start stays high
		abortMidSubframe();

		$display("Checks run: %0d, errors: %0d", checksRun, errorCount);
		if (errorCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
verilog/g729SeqPkg.sv
verilog/frameGate.sv
verilog/stepProgram.sv
verilog/stepController.sv
verilog/unitPort.sv
verilog/encoderSequencer.sv
test/encoderSequencerTb.sv
